// ==== zynq_shell_pkg.sv ====
package zynq_shell_pkg;

   // all addresses on the shell are 32 bits, set by the Zynq address map
   localparam int addr_width_lp = 32;
   localparam int data_width_lp = 32;

   // the core sees DRAM starting here; the XOR strips it before rebasing
   localparam logic [addr_width_lp-1:0] dram_bp_base_lp = 32'h8000_0000;

   // profiler regions are taken from address bits 29 down to 23
   localparam int num_regions_lp   = 128;
   localparam int region_msb_lp    = 29;
   localparam int region_width_lp  = 7;

   // channel 0 is the write address channel, channel 1 the read address channel
   localparam int num_chan_lp = 2;

   // CSR word map
   localparam int csr_addr_width_lp = 3;
   localparam logic [csr_addr_width_lp-1:0] csr_reset_idx_lp = 3'd0;
   localparam logic [csr_addr_width_lp-1:0] csr_alloc_idx_lp = 3'd1;
   localparam logic [csr_addr_width_lp-1:0] csr_base_idx_lp  = 3'd2;
   // profiler words follow from here, lowest word first
   localparam logic [csr_addr_width_lp-1:0] csr_prof_idx_lp  = 3'd3;

   // GP1 host window keeps this many low address bits
   localparam int host_offset_width_lp = 28;

   // one DRAM address word, read either as a plain address or split for the profiler
   typedef struct packed {
      logic [addr_width_lp-region_msb_lp-2:0]   upper;
      logic [region_width_lp-1:0]               region;
      logic [region_msb_lp-region_width_lp:0]   rest;
   } dram_addr_fields_s;

   typedef union packed {
      logic [addr_width_lp-1:0] raw;
      dram_addr_fields_s        prof;
   } dram_addr_u;

endpackage

// ==== dram_chan_if.sv ====
interface dram_chan_if;
   import zynq_shell_pkg::*;

   // request valid from the mapper stage
   logic                     v;
   // downstream accept, driven from the board side
   logic                     ready;
   // core-side address as it was captured
   dram_addr_u               bp_addr;
   // rebased address in ARM DRAM space
   logic [addr_width_lp-1:0] arm_addr;

   modport mapper (
      output v,
      output bp_addr,
      output arm_addr,
      input  ready
   );

   modport monitor (
      input v,
      input ready,
      input bp_addr,
      input arm_addr
   );

endinterface

// ==== shell_csr_regs.sv ====
module shell_csr_regs (
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   input  logic                                          csr_we_i,
   input  logic                                          csr_re_i,
   input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0]  csr_addr_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      csr_wdata_i,
   input  logic [zynq_shell_pkg::num_regions_lp-1:0]     prof_bits_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      csr_rdata_o,
   output logic                                          csr_rvalid_o,
   output logic                                          bp_reset_o,
   output logic [zynq_shell_pkg::addr_width_lp-1:0]      dram_base_o
);
   import zynq_shell_pkg::*;

   logic [data_width_lp-1:0] ctrl_r;
   logic [data_width_lp-1:0] alloc_r;
   logic [data_width_lp-1:0] base_r;
   logic [data_width_lp-1:0] rdata_n;
   logic [csr_addr_width_lp-1:0] prof_sel;
   logic [num_regions_lp/data_width_lp-1:0][data_width_lp-1:0] prof_words;

   assign prof_words = prof_bits_i;
   assign prof_sel   = csr_addr_i - csr_prof_idx_lp;

   // only the three PS-to-PL words are writable, the profiler words are read only
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_r  <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end else if (csr_we_i) begin
         case (csr_addr_i)
            csr_reset_idx_lp: ctrl_r  <= csr_wdata_i;
            csr_alloc_idx_lp: alloc_r <= csr_wdata_i;
            csr_base_idx_lp:  base_r  <= csr_wdata_i;
            default: ;
         endcase
      end
   end

   always_comb begin
      rdata_n = '0;
      case (csr_addr_i)
         csr_reset_idx_lp: rdata_n = ctrl_r;
         csr_alloc_idx_lp: rdata_n = alloc_r;
         csr_base_idx_lp:  rdata_n = base_r;
         default: begin
            // index 7 is past the last profiler word and reads as zero
            if (prof_sel < csr_addr_width_lp'(num_regions_lp / data_width_lp)) begin
               rdata_n = prof_words[prof_sel[1:0]];
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= csr_re_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_re_i) begin
         csr_rdata_o <= rdata_n;
      end
   end

   // the core stays in reset until software sets bit 0, so a new program can be
   // loaded without reprogramming the bitstream
   assign bp_reset_o  = !rst_n_i || !ctrl_r[0];
   assign dram_base_o = base_r;

   // the PS side issues one register access per cycle
   a_no_rw_overlap: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) !(csr_we_i && csr_re_i)
   );

endmodule

// ==== host_window_map.sv ====
module host_window_map (
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,
   input  logic                                      host_aw_v_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]  host_aw_addr_i,
   input  logic                                      host_ar_v_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]  host_ar_addr_i,
   output logic                                      bp_aw_v_o,
   output logic [zynq_shell_pkg::addr_width_lp-1:0]  bp_aw_addr_o,
   output logic                                      bp_ar_v_o,
   output logic [zynq_shell_pkg::addr_width_lp-1:0]  bp_ar_addr_o
);
   import zynq_shell_pkg::*;

   // GP1 offset 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx and offset
   // 0x2xxx_xxxx lands in the core's local space at 0x0xxx_xxxx
   function automatic logic [addr_width_lp-1:0] window_xlate(
      input logic [addr_width_lp-1:0] addr
   );
      return {~addr[host_offset_width_lp+1],
              {(addr_width_lp-host_offset_width_lp-1){1'b0}},
              addr[host_offset_width_lp-1:0]};
   endfunction

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         bp_aw_v_o <= 1'b0;
         bp_ar_v_o <= 1'b0;
      end else begin
         bp_aw_v_o <= host_aw_v_i;
         bp_ar_v_o <= host_ar_v_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (host_aw_v_i) begin
         bp_aw_addr_o <= window_xlate(host_aw_addr_i);
      end
      if (host_ar_v_i) begin
         bp_ar_addr_o <= window_xlate(host_ar_addr_i);
      end
   end

endmodule

// ==== dram_chan_mapper.sv ====
module dram_chan_mapper (
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,
   input  logic                                      bp_v_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]  bp_addr_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]  dram_base_i,
   output logic                                      bp_ready_o,
   dram_chan_if.mapper                               chan
);
   import zynq_shell_pkg::*;

   logic                     v_r;
   dram_addr_u               addr_n;
   dram_addr_u               addr_r;
   logic [addr_width_lp-1:0] arm_r;
   logic                     capture;

   assign addr_n.raw = bp_addr_i;

   // the single entry frees up in the same cycle that it drains
   assign bp_ready_o = !v_r || chan.ready;
   assign capture    = bp_v_i && bp_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         v_r <= 1'b0;
      end else if (capture) begin
         v_r <= 1'b1;
      end else if (chan.ready) begin
         v_r <= 1'b0;
      end
   end

   // XOR removes the core DRAM base, then the buffer that Linux allocated is added
   always_ff @(posedge clk_i) begin
      if (capture) begin
         addr_r <= addr_n;
         arm_r  <= (addr_n.raw ^ dram_bp_base_lp) + dram_base_i;
      end
   end

   assign chan.v        = v_r;
   assign chan.bp_addr  = addr_r;
   assign chan.arm_addr = arm_r;

   // a stalled request must not change under the downstream slave
   a_hold_stalled: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      chan.v && !chan.ready |=> chan.v && $stable(chan.bp_addr) && $stable(chan.arm_addr)
   );

   // valid can only come from a captured core request
   a_no_spurious_v: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !chan.v && !capture |=> !chan.v
   );

endmodule

// ==== mem_region_profiler.sv ====
module mem_region_profiler (
   input  logic                                   clk_i,
   input  logic                                   bp_reset_i,
   dram_chan_if.monitor                           chan_i [zynq_shell_pkg::num_chan_lp],
   output logic [zynq_shell_pkg::num_regions_lp-1:0] prof_bits_o
);
   import zynq_shell_pkg::*;

   logic [num_chan_lp-1:0][num_regions_lp-1:0] chan_mark;
   logic [num_regions_lp-1:0]                  mark_all;
   logic [num_regions_lp-1:0]                  prof_r;

   // a region counts as touched as soon as a request for it is presented
   for (genvar g = 0; g < num_chan_lp; g++) begin : g_mark
      assign chan_mark[g] = chan_i[g].v
                          ? num_regions_lp'(1) << chan_i[g].bp_addr.prof.region
                          : '0;
   end

   always_comb begin
      mark_all = '0;
      for (int i = 0; i < num_chan_lp; i++) begin
         mark_all = mark_all | chan_mark[i];
      end
   end

   // bits are sticky until the next core reset, which lets software
   // see how much memory a program used
   always_ff @(posedge clk_i) begin
      if (bp_reset_i) begin
         prof_r <= '0;
      end else begin
         prof_r <= prof_r | mark_all;
      end
   end

   assign prof_bits_o = prof_r;

endmodule

// ==== zynq_shell_top.sv ====
module zynq_shell_top (
   input  logic                                          clk_i,
   input  logic                                          rst_n_i,
   // PS-to-PL register access
   input  logic                                          csr_we_i,
   input  logic                                          csr_re_i,
   input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0]  csr_addr_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      csr_wdata_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      csr_rdata_o,
   output logic                                          csr_rvalid_o,
   output logic                                          bp_reset_o,
   // host accesses into the core through GP1
   input  logic                                          host_aw_v_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]      host_aw_addr_i,
   input  logic                                          host_ar_v_i,
   input  logic [zynq_shell_pkg::addr_width_lp-1:0]      host_ar_addr_i,
   output logic                                          bp_aw_v_o,
   output logic [zynq_shell_pkg::addr_width_lp-1:0]      bp_aw_addr_o,
   output logic                                          bp_ar_v_o,
   output logic [zynq_shell_pkg::addr_width_lp-1:0]      bp_ar_addr_o,
   // core DRAM address channels, index 0 write and index 1 read
   input  logic [zynq_shell_pkg::num_chan_lp-1:0]        dram_v_i,
   input  logic [zynq_shell_pkg::num_chan_lp-1:0][zynq_shell_pkg::addr_width_lp-1:0]
                                                         dram_addr_i,
   output logic [zynq_shell_pkg::num_chan_lp-1:0]        dram_ready_o,
   output logic [zynq_shell_pkg::num_chan_lp-1:0]        dram_v_o,
   output logic [zynq_shell_pkg::num_chan_lp-1:0][zynq_shell_pkg::addr_width_lp-1:0]
                                                         dram_addr_o,
   input  logic [zynq_shell_pkg::num_chan_lp-1:0]        dram_ready_i
);
   import zynq_shell_pkg::*;

   logic [addr_width_lp-1:0]  dram_base;
   logic [num_regions_lp-1:0] prof_bits;

   dram_chan_if chan [num_chan_lp] ();

   shell_csr_regs csr_regs (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .csr_we_i     (csr_we_i),
      .csr_re_i     (csr_re_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .prof_bits_i  (prof_bits),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .bp_reset_o   (bp_reset_o),
      .dram_base_o  (dram_base)
   );

   host_window_map host_map (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .host_aw_v_i    (host_aw_v_i),
      .host_aw_addr_i (host_aw_addr_i),
      .host_ar_v_i    (host_ar_v_i),
      .host_ar_addr_i (host_ar_addr_i),
      .bp_aw_v_o      (bp_aw_v_o),
      .bp_aw_addr_o   (bp_aw_addr_o),
      .bp_ar_v_o      (bp_ar_v_o),
      .bp_ar_addr_o   (bp_ar_addr_o)
   );

   // write and read channels are rebased the same way
   for (genvar g = 0; g < num_chan_lp; g++) begin : g_chan
      dram_chan_mapper mapper (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .bp_v_i      (dram_v_i[g]),
         .bp_addr_i   (dram_addr_i[g]),
         .dram_base_i (dram_base),
         .bp_ready_o  (dram_ready_o[g]),
         .chan        (chan[g])
      );

      assign chan[g].ready  = dram_ready_i[g];
      assign dram_v_o[g]    = chan[g].v;
      assign dram_addr_o[g] = chan[g].arm_addr;
   end

   mem_region_profiler profiler (
      .clk_i       (clk_i),
      .bp_reset_i  (bp_reset_o),
      .chan_i      (chan),
      .prof_bits_o (prof_bits)
   );

endmodule

// ==== tb_zynq_shell.sv ====
module tb_zynq_shell;
   import zynq_shell_pkg::*;

   localparam int num_csr_lp   = 40;
   localparam int num_host_lp  = 40;
   localparam int num_dram_lp  = 300;
   localparam int num_trans_lp = num_csr_lp + num_host_lp + num_dram_lp + 20;

   logic                                          clk;
   logic                                          rst_n;
   logic                                          csr_we;
   logic                                          csr_re;
   logic [csr_addr_width_lp-1:0]                  csr_addr;
   logic [data_width_lp-1:0]                      csr_wdata;
   logic [data_width_lp-1:0]                      csr_rdata;
   logic                                          csr_rvalid;
   logic                                          bp_reset;
   logic                                          host_aw_v;
   logic [addr_width_lp-1:0]                      host_aw_addr;
   logic                                          host_ar_v;
   logic [addr_width_lp-1:0]                      host_ar_addr;
   logic                                          bp_aw_v;
   logic [addr_width_lp-1:0]                      bp_aw_addr;
   logic                                          bp_ar_v;
   logic [addr_width_lp-1:0]                      bp_ar_addr;
   // core side of the DRAM channels
   logic [num_chan_lp-1:0]                        core_v;
   logic [num_chan_lp-1:0][addr_width_lp-1:0]     core_addr;
   logic [num_chan_lp-1:0]                        core_ready;
   // ARM DRAM side of the channels
   logic [num_chan_lp-1:0]                        arm_v;
   logic [num_chan_lp-1:0][addr_width_lp-1:0]     arm_addr;
   logic [num_chan_lp-1:0]                        arm_ready;

   int unsigned               checks;
   int unsigned               errors;
   logic [data_width_lp-1:0]  csr_model [3];
   logic [addr_width_lp-1:0]  base_model;
   logic [num_regions_lp-1:0] prof_model;
   logic [num_chan_lp-1:0]    pend_v;
   logic [addr_width_lp-1:0]  pend_arm [num_chan_lp];
   logic [region_width_lp-1:0] pend_region [num_chan_lp];
   int unsigned               accepted [num_chan_lp];
   int unsigned               drained [num_chan_lp];

   zynq_shell_top uut (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .csr_we_i       (csr_we),
      .csr_re_i       (csr_re),
      .csr_addr_i     (csr_addr),
      .csr_wdata_i    (csr_wdata),
      .csr_rdata_o    (csr_rdata),
      .csr_rvalid_o   (csr_rvalid),
      .bp_reset_o     (bp_reset),
      .host_aw_v_i    (host_aw_v),
      .host_aw_addr_i (host_aw_addr),
      .host_ar_v_i    (host_ar_v),
      .host_ar_addr_i (host_ar_addr),
      .bp_aw_v_o      (bp_aw_v),
      .bp_aw_addr_o   (bp_aw_addr),
      .bp_ar_v_o      (bp_ar_v),
      .bp_ar_addr_o   (bp_ar_addr),
      .dram_v_i       (core_v),
      .dram_addr_i    (core_addr),
      .dram_ready_o   (core_ready),
      .dram_v_o       (arm_v),
      .dram_addr_o    (arm_addr),
      .dram_ready_i   (arm_ready)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic csr_write(input logic [2:0] idx, input logic [31:0] data);
      @(negedge clk);
      csr_we    = 1'b1;
      csr_addr  = idx;
      csr_wdata = data;
      @(negedge clk);
      csr_we = 1'b0;
   endtask

   // rvalid must be low before the strobe and high exactly one cycle after it
   task automatic csr_read(input logic [2:0] idx, output logic [31:0] data);
      @(negedge clk);
      check_value("csr_rvalid_idle", 0, csr_rvalid);
      csr_re   = 1'b1;
      csr_addr = idx;
      @(negedge clk);
      csr_re = 1'b0;
      check_value("csr_rvalid", 1, csr_rvalid);
      data = csr_rdata;
   endtask

   task automatic read_prof_words(input string name);
      logic [31:0] rd;
      for (int w = 0; w < num_regions_lp / data_width_lp; w++) begin
         csr_read(3'(csr_prof_idx_lp + w), rd);
         check_value(name, prof_model[w*data_width_lp +: data_width_lp], rd);
      end
   endtask

   // one clock of DRAM traffic, the model follows the valid/ready rule of each channel
   task automatic dram_cycle(input bit traffic);
      @(negedge clk);
      for (int c = 0; c < num_chan_lp; c++) begin
         check_value("dram_v_o", pend_v[c], arm_v[c]);
         if (pend_v[c]) begin
            check_value("dram_addr_o", pend_arm[c], arm_addr[c]);
         end
         core_v[c]    = traffic && ($urandom_range(0, 3) != 0);
         core_addr[c] = $urandom;
         arm_ready[c] = !traffic || ($urandom_range(0, 1) == 1);
      end
      #1;
      for (int c = 0; c < num_chan_lp; c++) begin
         check_value("dram_ready_o", !pend_v[c] || arm_ready[c], core_ready[c]);
         if (arm_v[c] && arm_ready[c]) begin
            drained[c]++;
         end
         // the profiler marks on valid, even while the request is stalled
         if (pend_v[c]) begin
            prof_model[pend_region[c]] = 1'b1;
         end
         if (pend_v[c] && arm_ready[c]) begin
            pend_v[c] = 1'b0;
         end
         if (core_v[c] && !pend_v[c]) begin
            pend_v[c]      = 1'b1;
            pend_arm[c]    = (core_addr[c] ^ 32'h8000_0000) + base_model;
            pend_region[c] = core_addr[c][29:23];
            accepted[c]++;
         end
      end
   endtask

   initial begin
      #(num_trans_lp * 20 * 20);
      $display("timeout: the testbench did not reach its end in time");
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [31:0] rd;
      logic [31:0] data;
      logic [2:0]  idx;
      void'($urandom(32'h4bec_0ade));
      checks = 0;
      errors = 0;
      rst_n = 1'b0;
      csr_we = 1'b0;
      csr_re = 1'b0;
      csr_addr = '0;
      csr_wdata = '0;
      host_aw_v = 1'b0;
      host_aw_addr = '0;
      host_ar_v = 1'b0;
      host_ar_addr = '0;
      core_v = '0;
      core_addr = '0;
      arm_ready = '0;
      pend_v = '0;
      prof_model = '0;
      base_model = '0;
      for (int c = 0; c < num_chan_lp; c++) begin
         accepted[c] = 0;
         drained[c]  = 0;
      end
      for (int i = 0; i < 3; i++) begin
         csr_model[i] = '0;
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("reset_bp_reset", 1, bp_reset);
      check_value("reset_dram_ready", 2'b11, core_ready);
      check_value("reset_dram_v", 0, arm_v);
      check_value("reset_host_v", 0, {bp_aw_v, bp_ar_v});
      check_value("reset_rvalid", 0, csr_rvalid);

      csr_write(csr_reset_idx_lp, 32'h1);
      check_value("soft_reset_release", 0, bp_reset);
      csr_write(csr_reset_idx_lp, 32'h0);
      check_value("soft_reset_assert", 1, bp_reset);

      for (int i = 0; i < num_csr_lp; i++) begin
         idx  = 3'($urandom_range(0, 2));
         data = $urandom;
         csr_write(idx, data);
         csr_model[idx] = data;
         check_value("csr_bp_reset", !csr_model[0][0], bp_reset);
         idx = 3'($urandom_range(0, 2));
         csr_read(idx, rd);
         check_value("csr_readback", csr_model[idx], rd);
      end

      // outputs seen at each falling edge belong to the inputs of the cycle before
      for (int i = 0; i <= num_host_lp; i++) begin
         @(negedge clk);
         check_value("host_aw_v", host_aw_v, bp_aw_v);
         check_value("host_ar_v", host_ar_v, bp_ar_v);
         if (host_aw_v) begin
            check_value("host_aw_addr", {~host_aw_addr[29], 3'b000, host_aw_addr[27:0]},
                        bp_aw_addr);
         end
         if (host_ar_v) begin
            check_value("host_ar_addr", {~host_ar_addr[29], 3'b000, host_ar_addr[27:0]},
                        bp_ar_addr);
         end
         host_aw_v    = (i < num_host_lp) && ($urandom_range(0, 3) != 0);
         host_aw_addr = $urandom;
         host_ar_v    = (i < num_host_lp) && ($urandom_range(0, 3) != 0);
         host_ar_addr = $urandom;
      end

      base_model = $urandom;
      csr_write(csr_base_idx_lp, base_model);
      csr_write(csr_reset_idx_lp, 32'h1);
      prof_model = '0;
      repeat (num_dram_lp) dram_cycle(1'b1);
      repeat (4) dram_cycle(1'b0);
      for (int c = 0; c < num_chan_lp; c++) begin
         check_value("dram_transfer_count", accepted[c], drained[c]);
      end
      read_prof_words("prof_after_traffic");

      // profiler words are read only
      for (int w = 0; w < num_regions_lp / data_width_lp; w++) begin
         csr_write(3'(csr_prof_idx_lp + w), $urandom);
      end
      read_prof_words("prof_write_ignored");

      csr_write(csr_reset_idx_lp, 32'h0);
      prof_model = '0;
      read_prof_words("prof_soft_reset");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
zynq_shell_pkg.sv
dram_chan_if.sv
shell_csr_regs.sv
host_window_map.sv
dram_chan_mapper.sv
mem_region_profiler.sv
zynq_shell_top.sv
tb_zynq_shell.sv
